//--- Makefile
VERILATOR ?= verilator
TOP       ?= blit_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
source/blit_pkg.sv
source/blit_rect_walker.sv
source/blit_address.sv
source/blit_fetch.sv
source/blit_colour_out.sv
source/blit_top.sv
verification/blit_props.sv
verification/blit_tb.sv

//--- source/blit_address.sv
`timescale 1ns/1ps

module blit_address (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [blit_pkg::addr_w-1:0]   cmd_sheet_base,
    input  logic [blit_pkg::coord_w-1:0]  sheet_width,
    input  blit_pkg::depth_e              depth,
    input  blit_pkg::rect_item_t          in_item,
    input  logic                          in_valid,
    output logic                          in_ready,
    output blit_pkg::fetch_item_t         out_item,
    output logic                          out_valid,
    input  logic                          out_ready
);
    import blit_pkg::*;

    typedef enum logic [1:0] {
        st_empty,
        st_full,
        st_buf_full
    } buf_state_e;

    buf_state_e         state;
    logic [addr_w-1:0]  pixel_index;
    logic [addr_w+4:0]  bit_pos;     // room for index * 16
    fetch_item_t        result;
    fetch_item_t        spare;       // second entry, absorbs one stall
    logic               in_xfer;
    logic               out_xfer;

    assign in_xfer   = in_valid && in_ready;
    assign out_xfer  = out_valid && out_ready;
    assign out_valid = (state != st_empty);

    always_comb begin
        pixel_index = addr_w'(in_item.sheet_x) + addr_w'(sheet_width) * addr_w'(in_item.sheet_y);
        bit_pos = (addr_w+5)'(pixel_index) * (addr_w+5)'(depth);
        result.word_addr  = cmd_sheet_base + addr_w'({bit_pos[addr_w+4:5], 2'b00});
        result.bit_offset = bit_pos[4:0];
        result.pos        = in_item.pos;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_empty;
            in_ready <= 1'b0;
        end else begin
            case (state)
                st_empty: begin
                    in_ready <= 1'b1;
                    if (in_xfer) begin
                        out_item <= result;
                        state    <= st_full;
                    end
                end
                st_full: begin
                    if (in_xfer && !out_xfer) begin
                        spare    <= result;
                        in_ready <= 1'b0;
                        state    <= st_buf_full;
                    end else if (in_xfer) begin
                        out_item <= result;
                    end else if (out_xfer) begin
                        state <= st_empty;
                    end
                end
                default: begin
                    if (out_xfer) begin
                        out_item <= spare;
                        in_ready <= 1'b1;
                        state    <= st_full;
                    end
                end
            endcase
        end
    end

endmodule

//--- source/blit_colour_out.sv
`timescale 1ns/1ps

module blit_colour_out (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ct_enable,
    input  logic [blit_pkg::pixel_w-1:0]  ct_offset,
    input  blit_pkg::colour_src_e         colour_src,
    input  logic [blit_pkg::pixel_w-1:0]  fill_colour,
    input  blit_pkg::pixel_item_t         in_item,
    input  logic                          in_valid,
    output logic [blit_pkg::pixel_w-1:0]  ct_address,
    input  logic [blit_pkg::pixel_w-1:0]  ct_colour,
    output blit_pkg::fb_pos_t             fb_pos,
    output logic [blit_pkg::pixel_w-1:0]  fb_colour,
    output logic                          fb_write
);
    import blit_pkg::*;

    logic        s1_valid;
    fb_pos_t     s1_pos;
    pixel_word_u s1_pixel;

    // stage 1, table lookup issued
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
        ct_address <= in_item.pixel.index + ct_offset;
        s1_pos     <= in_item.pos;
        s1_pixel   <= in_item.pixel;
    end

    // stage 2, table data arrives this cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            fb_write <= 1'b0;
        end else begin
            fb_write <= s1_valid;
        end
        fb_pos <= s1_pos;
        if (colour_src == colour_fill) begin
            fb_colour <= fill_colour;
        end else if (ct_enable) begin
            fb_colour <= ct_colour;
        end else begin
            fb_colour <= s1_pixel.rgb;   // field taken as a direct colour
        end
    end

endmodule

//--- source/blit_fetch.sv
`timescale 1ns/1ps

module blit_fetch (
    input  logic                         clk,
    input  logic                         rst,
    input  blit_pkg::depth_e             depth,
    input  blit_pkg::fetch_item_t        in_item,
    input  logic                         in_valid,
    output logic                         in_ready,
    output logic [blit_pkg::addr_w-1:0]  m_axil_araddr,
    output logic                         m_axil_arvalid,
    input  logic                         m_axil_arready,
    input  logic [blit_pkg::word_w-1:0]  m_axil_rdata,
    input  logic                         m_axil_rvalid,
    output logic                         m_axil_rready,
    output blit_pkg::pixel_item_t        out_item,
    output logic                         out_valid,
    input  logic                         out_ready
);
    import blit_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_hold
    } fetch_state_e;

    // LSB-first field of depth bits starting at offset
    function automatic logic [pixel_w-1:0] extract_field(
        input logic [word_w-1:0] word,
        input logic [4:0]        offset,
        input depth_e            d
    );
        logic [word_w-1:0] mask;
        logic [word_w-1:0] shifted;
        mask    = (word_w'(1) << d) - word_w'(1);
        shifted = (word >> offset) & mask;
        return shifted[pixel_w-1:0];
    endfunction

    fetch_state_e      state;
    fetch_item_t       req;
    logic [addr_w-1:0] cache_addr;
    logic [word_w-1:0] cache_data;
    logic              cache_valid;
    logic              hit;
    logic              in_xfer;

    assign in_xfer = in_valid && in_ready;
    assign hit     = cache_valid && (cache_addr == in_item.word_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= st_idle;
            in_ready       <= 1'b0;
            out_valid      <= 1'b0;
            m_axil_arvalid <= 1'b0;
            m_axil_rready  <= 1'b0;
            cache_valid    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    in_ready <= 1'b1;
                    if (in_xfer) begin
                        in_ready <= 1'b0;
                        req      <= in_item;
                        if (hit) begin
                            out_item.pixel.index <= extract_field(cache_data,
                                                                  in_item.bit_offset, depth);
                            out_item.pos <= in_item.pos;
                            out_valid    <= 1'b1;
                            state        <= st_hold;
                        end else begin
                            m_axil_araddr  <= in_item.word_addr;
                            m_axil_arvalid <= 1'b1;
                            state          <= st_addr;
                        end
                    end
                end
                st_addr: begin
                    if (m_axil_arready) begin
                        m_axil_arvalid <= 1'b0;
                        m_axil_rready  <= 1'b1;
                        state          <= st_data;
                    end
                end
                st_data: begin
                    if (m_axil_rvalid) begin
                        m_axil_rready <= 1'b0;
                        cache_data    <= m_axil_rdata;
                        cache_addr    <= req.word_addr;
                        cache_valid   <= 1'b1;
                        out_item.pixel.index <= extract_field(m_axil_rdata,
                                                              req.bit_offset, depth);
                        out_item.pos <= req.pos;
                        out_valid    <= 1'b1;
                        state        <= st_hold;
                    end
                end
                default: begin
                    if (out_ready) begin    // out_valid is high here
                        out_valid <= 1'b0;
                        in_ready  <= 1'b1;
                        state     <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- source/blit_pkg.sv
package blit_pkg;

    localparam int coord_w = 16;
    localparam int addr_w  = 32;
    localparam int word_w  = 32;
    localparam int pixel_w = 16;

    // bits per pixel, encoded as the bit count
    typedef enum logic [4:0] {
        depth_1  = 5'd1,
        depth_2  = 5'd2,
        depth_4  = 5'd4,
        depth_8  = 5'd8,
        depth_16 = 5'd16
    } depth_e;

    typedef enum logic {
        colour_memory = 1'b0,
        colour_fill   = 1'b1
    } colour_src_e;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // same 16 bits read either as a colour or as a table index
    typedef union packed {
        rgb565_t            rgb;
        logic [pixel_w-1:0] index;
    } pixel_word_u;

    typedef struct packed {
        logic [addr_w-1:0]         sheet_base;    // word aligned
        logic [coord_w-1:0]        sheet_width;
        logic [coord_w-1:0]        src_x;
        logic [coord_w-1:0]        src_y;
        logic [coord_w-1:0]        screen_x;
        logic [coord_w-1:0]        screen_y;
        logic [coord_w-1:0]        excerpt_width;
        logic [coord_w-1:0]        excerpt_height;
        logic signed [coord_w-1:0] scale_x;       // >0 upscale, <0 downscale
        logic signed [coord_w-1:0] scale_y;
        logic                      mirror_x;
        logic                      mirror_y;
        depth_e                    depth;
        logic                      ct_enable;
        logic [pixel_w-1:0]        ct_offset;
        colour_src_e               colour_src;
        logic [pixel_w-1:0]        fill_colour;
    } draw_cmd_t;

    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
    } fb_pos_t;

    typedef struct packed {
        logic [coord_w-1:0] sheet_x;
        logic [coord_w-1:0] sheet_y;
        fb_pos_t            pos;
    } rect_item_t;

    typedef struct packed {
        logic [addr_w-1:0] word_addr;
        logic [4:0]        bit_offset;
        fb_pos_t           pos;
    } fetch_item_t;

    typedef struct packed {
        pixel_word_u pixel;
        fb_pos_t     pos;
    } pixel_item_t;

endpackage

//--- source/blit_rect_walker.sv
`timescale 1ns/1ps

module blit_rect_walker (
    input  logic                clk,
    input  logic                rst,
    input  blit_pkg::draw_cmd_t cmd,
    input  logic                draw,
    output logic                busy,
    output blit_pkg::rect_item_t out_item,
    output logic                out_valid,
    input  logic                out_ready
);
    import blit_pkg::*;

    // magnitude of a signed scale, zero counts as one
    function automatic logic [coord_w-1:0] scale_mag(input logic [coord_w-1:0] s);
        logic [coord_w-1:0] m;
        m = s[coord_w-1] ? -s : s;
        return (m == '0) ? coord_w'(1) : m;
    endfunction

    logic [coord_w-1:0] i;
    logic [coord_w-1:0] j;
    logic [coord_w-1:0] sub_x;      // repeat counters for upscale
    logic [coord_w-1:0] sub_y;
    logic [coord_w-1:0] sheet_x;
    logic [coord_w-1:0] sheet_y;
    logic [coord_w-1:0] mag_x;
    logic [coord_w-1:0] mag_y;
    logic [coord_w-1:0] last_i;
    logic [coord_w-1:0] last_j;
    logic               up_x;
    logic               up_y;
    logic               out_xfer;

    assign mag_x    = scale_mag(cmd.scale_x);
    assign mag_y    = scale_mag(cmd.scale_y);
    assign up_x     = !cmd.scale_x[coord_w-1];
    assign up_y     = !cmd.scale_y[coord_w-1];
    assign last_i   = cmd.excerpt_width - 1'b1;
    assign last_j   = cmd.excerpt_height - 1'b1;
    assign out_valid = busy;
    assign out_xfer = out_valid && out_ready;

    always_comb begin
        out_item.sheet_x = sheet_x;
        out_item.sheet_y = sheet_y;
        out_item.pos.x = cmd.mirror_x ? cmd.screen_x + last_i - i : cmd.screen_x + i;
        out_item.pos.y = cmd.mirror_y ? cmd.screen_y + last_j - j : cmd.screen_y + j;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy) begin
            if (draw) begin
                busy    <= 1'b1;
                i       <= '0;
                j       <= '0;
                sub_x   <= '0;
                sub_y   <= '0;
                sheet_x <= cmd.src_x;
                sheet_y <= cmd.src_y;
            end
        end else if (out_xfer) begin
            if (i == last_i) begin
                // end of row, rewind x and step y
                i       <= '0;
                sub_x   <= '0;
                sheet_x <= cmd.src_x;
                j       <= j + 1'b1;
                if (j == last_j) begin
                    busy <= 1'b0;
                end
                if (!up_y) begin
                    sheet_y <= sheet_y + mag_y;
                end else if (sub_y == mag_y - 1'b1) begin
                    sub_y   <= '0;
                    sheet_y <= sheet_y + 1'b1;
                end else begin
                    sub_y <= sub_y + 1'b1;
                end
            end else begin
                i <= i + 1'b1;
                if (!up_x) begin
                    sheet_x <= sheet_x + mag_x;   // skip source pixels
                end else if (sub_x == mag_x - 1'b1) begin
                    sub_x   <= '0;
                    sheet_x <= sheet_x + 1'b1;
                end else begin
                    sub_x <= sub_x + 1'b1;
                end
            end
        end
    end

endmodule

//--- source/blit_top.sv
`timescale 1ns/1ps

module blit_top (
    input  logic                          clk,
    input  logic                          rst,
    input  blit_pkg::draw_cmd_t           cmd,
    input  logic                          draw,
    output logic                          busy,
    output logic [blit_pkg::addr_w-1:0]   m_axil_araddr,
    output logic                          m_axil_arvalid,
    input  logic                          m_axil_arready,
    input  logic [blit_pkg::word_w-1:0]   m_axil_rdata,
    input  logic                          m_axil_rvalid,
    output logic                          m_axil_rready,
    output logic [blit_pkg::pixel_w-1:0]  ct_address,
    input  logic [blit_pkg::pixel_w-1:0]  ct_colour,
    output blit_pkg::fb_pos_t             fb_pos,
    output logic [blit_pkg::pixel_w-1:0]  fb_colour,
    output logic                          fb_write
);
    import blit_pkg::*;

    rect_item_t  walk_item;
    logic        walk_valid;
    logic        addr_ready;
    fetch_item_t addr_item;
    logic        addr_valid;
    logic        fetch_ready;
    pixel_item_t fetch_item;
    logic        fetch_valid;

    blit_rect_walker u_walker (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .draw      (draw),
        .busy      (busy),
        .out_item  (walk_item),
        .out_valid (walk_valid),
        .out_ready (addr_ready)
    );

    blit_address u_address (
        .clk            (clk),
        .rst            (rst),
        .cmd_sheet_base (cmd.sheet_base),
        .sheet_width    (cmd.sheet_width),
        .depth          (cmd.depth),
        .in_item        (walk_item),
        .in_valid       (walk_valid),
        .in_ready       (addr_ready),
        .out_item       (addr_item),
        .out_valid      (addr_valid),
        .out_ready      (fetch_ready)
    );

    blit_fetch u_fetch (
        .clk            (clk),
        .rst            (rst),
        .depth          (cmd.depth),
        .in_item        (addr_item),
        .in_valid       (addr_valid),
        .in_ready       (fetch_ready),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_rdata   (m_axil_rdata),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_rready  (m_axil_rready),
        .out_item       (fetch_item),
        .out_valid      (fetch_valid),
        .out_ready      (1'b1)           // colour stage never stalls
    );

    blit_colour_out u_colour_out (
        .clk         (clk),
        .rst         (rst),
        .ct_enable   (cmd.ct_enable),
        .ct_offset   (cmd.ct_offset),
        .colour_src  (cmd.colour_src),
        .fill_colour (cmd.fill_colour),
        .in_item     (fetch_item),
        .in_valid    (fetch_valid),
        .ct_address  (ct_address),
        .ct_colour   (ct_colour),
        .fb_pos      (fb_pos),
        .fb_colour   (fb_colour),
        .fb_write    (fb_write)
    );

endmodule

//--- verification/blit_props.sv
`timescale 1ns/1ps

module blit_props (
    input logic                        clk,
    input logic                        rst,
    input logic                        busy,
    input logic [blit_pkg::addr_w-1:0] m_axil_araddr,
    input logic                        m_axil_arvalid,
    input logic                        m_axil_arready,
    input logic                        m_axil_rready,
    input logic                        fb_write
);

    // address phase holds until accepted
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid && !m_axil_arready |=> m_axil_arvalid && $stable(m_axil_araddr))
        else $error("arvalid or araddr changed before arready");

    ar_aligned: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid |-> m_axil_araddr[1:0] == 2'b00)
        else $error("araddr not word aligned");

    fb_quiet_reset: assert property (@(posedge clk) rst |=> !fb_write)
        else $error("fb_write high during or right after reset");

    reset_state: assert property (@(posedge clk)
        rst |=> !busy && !m_axil_arvalid && !m_axil_rready)
        else $error("busy or AXI handshake high after a reset cycle");

endmodule

bind blit_top blit_props u_props (
    .clk            (clk),
    .rst            (rst),
    .busy           (busy),
    .m_axil_araddr  (m_axil_araddr),
    .m_axil_arvalid (m_axil_arvalid),
    .m_axil_arready (m_axil_arready),
    .m_axil_rready  (m_axil_rready),
    .fb_write       (fb_write)
);

//--- verification/blit_tb.sv
`timescale 1ns/1ps

module blit_tb;
    import blit_pkg::*;

    localparam int mem_words       = 4096;
    localparam int total_pixels    = 132;    // all draws below together
    localparam int watchdog_cycles = total_pixels * 40 + 1000;

    typedef struct packed {
        fb_pos_t            pos;
        logic [pixel_w-1:0] colour;
    } fb_write_t;

    logic               clk;
    logic               rst;
    draw_cmd_t          cmd;
    logic               draw;
    logic               busy;
    logic [addr_w-1:0]  m_axil_araddr;
    logic               m_axil_arvalid;
    logic               m_axil_arready;
    logic [word_w-1:0]  m_axil_rdata;
    logic               m_axil_rvalid;
    logic               m_axil_rready;
    logic [pixel_w-1:0] ct_address;
    logic [pixel_w-1:0] ct_colour;
    fb_pos_t            fb_pos;
    logic [pixel_w-1:0] fb_colour;
    logic               fb_write;

    logic [word_w-1:0]  mem [0:mem_words-1];
    logic [pixel_w-1:0] ct_table [0:65535];
    fb_write_t          expect_q [$];     // writes still to come, raster order
    integer             seed;
    logic               slow_mem;
    logic [1:0]         mem_phase;
    int                 mem_wait;
    logic [word_w-1:0]  rd_word;
    int                 error_count;
    int                 check_count;
    int                 test_count;

    blit_top UUT (
        .clk            (clk),
        .rst            (rst),
        .cmd            (cmd),
        .draw           (draw),
        .busy           (busy),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_rdata   (m_axil_rdata),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_rready  (m_axil_rready),
        .ct_address     (ct_address),
        .ct_colour      (ct_colour),
        .fb_pos         (fb_pos),
        .fb_colour      (fb_colour),
        .fb_write       (fb_write)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // address registered inside the DUT, data ready one cycle after the item
    assign ct_colour = ct_table[ct_address];

    function automatic int pick_delay();
        if (slow_mem) begin
            return 3;
        end
        return $unsigned($random(seed)) % 4;
    endfunction

    // AXI-Lite read slave, phases: wait ar, delay r, present r
    always @(posedge clk) begin
        if (rst) begin
            m_axil_arready <= 1'b0;
            m_axil_rvalid  <= 1'b0;
            mem_phase      <= 2'd0;
            mem_wait       <= 0;
        end else begin
            m_axil_arready <= 1'b0;
            case (mem_phase)
                2'd0: begin
                    if (m_axil_arvalid && !m_axil_arready) begin
                        if (mem_wait == 0) begin
                            m_axil_arready <= 1'b1;
                            rd_word        <= mem[m_axil_araddr[13:2]];
                            mem_wait       <= pick_delay();
                            mem_phase      <= 2'd1;
                        end else begin
                            mem_wait <= mem_wait - 1;
                        end
                    end
                end
                2'd1: begin
                    if (mem_wait == 0) begin
                        m_axil_rvalid <= 1'b1;
                        m_axil_rdata  <= rd_word;
                        mem_phase     <= 2'd2;
                    end else begin
                        mem_wait <= mem_wait - 1;
                    end
                end
                default: begin
                    if (m_axil_rvalid && m_axil_rready) begin
                        m_axil_rvalid <= 1'b0;
                        mem_wait      <= pick_delay();
                        mem_phase     <= 2'd0;
                    end
                end
            endcase
        end
    end

    // each fb write must match the head of the expected queue
    always @(negedge clk) begin
        fb_write_t want;
        if (!rst && fb_write) begin
            if (expect_q.size() == 0) begin
                $display("** Error at %0t: fb_write pulsed with no write outstanding", $time);
                error_count++;
            end else begin
                want = expect_q.pop_front();
                check_count++;
                if (fb_pos !== want.pos) begin
                    $display("** Error at %0t: fb_pos = (%0d,%0d), expected (%0d,%0d)", $time,
                             fb_pos.x, fb_pos.y, want.pos.x, want.pos.y);
                    error_count++;
                end
                if (fb_colour !== want.colour) begin
                    $display("** Error at %0t: fb_colour = %h, expected %h", $time,
                             fb_colour, want.colour);
                    error_count++;
                end
            end
        end
    end

    function automatic int sheet_coord(input int src, input int scale, input int k);
        if (scale == 0) begin
            scale = 1;
        end
        if (scale > 0) begin
            return src + k / scale;
        end
        return src + k * (-scale);
    endfunction

    // pixel field straight from the memory array, LSB-first
    function automatic int pixel_field(input draw_cmd_t c, input int sx, input int sy);
        longint      bit_pos;
        longint      byte_addr;
        logic [31:0] w;
        bit_pos   = (longint'(sx) + longint'(c.sheet_width) * sy) * longint'(c.depth);
        byte_addr = longint'(c.sheet_base) + bit_pos / 8;
        w         = mem[(byte_addr / 4) % mem_words];
        return int'((w >> (bit_pos % 32)) & ((32'd1 << c.depth) - 1));
    endfunction

    function automatic logic [pixel_w-1:0] expected_colour(input draw_cmd_t c,
                                                           input int sx, input int sy);
        int field;
        field = pixel_field(c, sx, sy);
        if (c.colour_src == colour_fill) begin
            return c.fill_colour;
        end
        if (c.ct_enable) begin
            return ct_table[pixel_w'(field + int'(c.ct_offset))];
        end
        return pixel_w'(field);
    endfunction

    function automatic draw_cmd_t default_cmd(input depth_e d, input int w, input int h);
        draw_cmd_t c;
        c                = '0;
        c.sheet_base     = 32'h400;
        c.sheet_width    = 16;
        c.screen_x       = 40;
        c.screen_y       = 20;
        c.excerpt_width  = coord_w'(w);
        c.excerpt_height = coord_w'(h);
        c.scale_x        = 1;
        c.scale_y        = 1;
        c.depth          = d;
        c.colour_src     = colour_memory;
        return c;
    endfunction

    task automatic run_draw(input draw_cmd_t c);
        fb_write_t w;
        int        sx;
        int        sy;
        for (int j = 0; j < int'(c.excerpt_height); j++) begin
            for (int i = 0; i < int'(c.excerpt_width); i++) begin
                w.pos.x = coord_w'(c.mirror_x ? int'(c.screen_x) + int'(c.excerpt_width) - 1 - i
                                              : int'(c.screen_x) + i);
                w.pos.y = coord_w'(c.mirror_y ? int'(c.screen_y) + int'(c.excerpt_height) - 1 - j
                                              : int'(c.screen_y) + j);
                sx = sheet_coord(int'(c.src_x), int'(c.scale_x), i);
                sy = sheet_coord(int'(c.src_y), int'(c.scale_y), j);
                w.colour = expected_colour(c, sx, sy);
                expect_q.push_back(w);
            end
        end
        @(posedge clk);
        cmd  <= c;
        draw <= 1'b1;
        @(posedge clk);
        draw <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b1) begin
            $display("** Error at %0t: busy = %b, expected 1", $time, busy);
            error_count++;
        end
        while (expect_q.size() != 0 || busy) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
    endtask

    task automatic reset_and_direct_draw();
        int        e0;
        draw_cmd_t c;
        e0 = error_count;
        @(negedge clk);
        if (busy !== 1'b0 || fb_write !== 1'b0) begin
            $display("** Error at %0t: busy/fb_write = %b/%b after reset, expected 0/0",
                     $time, busy, fb_write);
            error_count++;
        end
        if (m_axil_arvalid !== 1'b0 || m_axil_rready !== 1'b0) begin
            $display("** Error at %0t: arvalid/rready = %b/%b after reset, expected 0/0",
                     $time, m_axil_arvalid, m_axil_rready);
            error_count++;
        end
        c = default_cmd(depth_16, 4, 3);
        c.src_x = 3;
        c.src_y = 2;
        run_draw(c);
        report_test("reset state and 16 bpp direct", e0);
    endtask

    task automatic colour_table_draw();
        int        e0;
        draw_cmd_t c;
        e0 = error_count;
        c = default_cmd(depth_8, 5, 2);
        c.sheet_base = 32'h800;
        c.src_x      = 4;
        c.src_y      = 3;
        c.ct_enable  = 1'b1;
        c.ct_offset  = 16'h0040;
        run_draw(c);
        report_test("8 bpp colour table", e0);
    endtask

    task automatic mirrored_upscale_draw();
        int        e0;
        draw_cmd_t c;
        e0 = error_count;
        c = default_cmd(depth_4, 6, 6);
        c.sheet_width = 24;
        c.src_x       = 2;
        c.src_y       = 1;
        c.scale_x     = 2;
        c.scale_y     = 3;
        c.mirror_x    = 1'b1;
        c.mirror_y    = 1'b1;
        run_draw(c);
        report_test("4 bpp mirrored upscale", e0);
    endtask

    task automatic downscale_low_depth_draws();
        int        e0;
        draw_cmd_t c;
        e0 = error_count;
        c = default_cmd(depth_1, 7, 3);
        c.sheet_width = 37;      // odd, rows start mid-word
        c.src_x       = 5;
        c.src_y       = 3;
        c.scale_x     = -3;
        c.scale_y     = -2;
        run_draw(c);
        c = default_cmd(depth_2, 5, 4);
        c.sheet_base  = 32'h1000;
        c.sheet_width = 13;
        c.src_x       = 1;
        c.src_y       = 2;
        c.scale_x     = -2;
        c.scale_y     = -1;
        run_draw(c);
        report_test("1 and 2 bpp downscale", e0);
    endtask

    task automatic fill_draw();
        int        e0;
        draw_cmd_t c;
        e0 = error_count;
        c = default_cmd(depth_8, 3, 3);
        c.colour_src  = colour_fill;
        c.fill_colour = 16'hbeef;
        c.ct_enable   = 1'b1;     // fill wins over the table
        run_draw(c);
        report_test("fill colour", e0);
    endtask

    task automatic back_to_back_draws();
        int        e0;
        draw_cmd_t c;
        e0 = error_count;
        slow_mem = 1'b1;
        c = default_cmd(depth_16, 6, 2);
        c.src_x    = 1;
        c.screen_x = 100;
        run_draw(c);
        c = default_cmd(depth_4, 3, 4);
        c.sheet_base = 32'hc00;
        c.ct_enable  = 1'b1;
        c.ct_offset  = 16'h1234;
        run_draw(c);
        slow_mem = 1'b0;
        report_test("back-to-back draws, slow memory", e0);
    endtask

    initial begin
        seed           = 80;
        slow_mem       = 1'b0;
        error_count    = 0;
        check_count    = 0;
        test_count     = 0;
        rst            = 1'b1;
        draw           = 1'b0;
        cmd            = '0;
        m_axil_arready = 1'b0;
        m_axil_rvalid  = 1'b0;
        m_axil_rdata   = '0;
        for (int k = 0; k < mem_words; k++) begin
            mem[k] = (k * 32'h9e3779b1) ^ {k[15:0], ~k[15:0]};
        end
        for (int k = 0; k < 65536; k++) begin
            ct_table[k] = pixel_w'(k * 16'h03b9) ^ 16'h5a00;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_and_direct_draw();
        colour_table_draw();
        mirrored_upscale_draw();
        downscale_low_depth_draws();
        fill_draw();
        back_to_back_draws();
        repeat (8) @(posedge clk);    // catch stray writes
        $display("summary: %0d tests, %0d writes checked, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run still going after %0d cycles", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

endmodule
